// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_tb_fetch_top

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_fetch_top --Mdir "$OBJ" -o "$BIN" -f rvfetch.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/$BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
exit 1

// ==== rvfetch.f ====
source/fetch_pkg.sv
source/fetch_if.sv
source/compressed_decoder.sv
source/prefetch_buffer.sv
source/if_stage.sv
source/fetch_top.sv
tb/fetch_top_checker.sv
tb/tb_fetch_top.sv

// ==== source/compressed_decoder.sv ====
// --------------------------------------
// compressed decoder
// expands C.ADDI, C.LI, C.MV and C.ADD to
// their 32-bit forms, flags all other RVC
// --------------------------------------
`timescale 1ns/1ps

module compressed_decoder import fetch_pkg::*; (
    input  logic [INSTR_W-1:0] instr_i,
    output logic [INSTR_W-1:0] instr_o,
    output logic               is_compressed_o,
    output logic               illegal_instr_o
);

    logic [11:0] imm_ci;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [2:0]  funct3;
    logic [3:0]  funct4;

    // CI-format immediate, sign bit in [12]
    assign imm_ci = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2]};
    assign rd     = instr_i[11:7];
    assign rs2    = instr_i[6:2];
    assign funct3 = instr_i[15:13];
    assign funct4 = instr_i[15:12];

    // anything but 2'b11 in the low bits is compressed
    assign is_compressed_o = (instr_i[1:0] != 2'b11);

    always_comb begin
        instr_o         = instr_i;
        illegal_instr_o = 1'b0;

        if (is_compressed_o) begin
            // default for unsupported encodings
            instr_o         = '0;
            illegal_instr_o = 1'b1;

            unique case (instr_i[1:0])
                OPC_C1: begin
                    if (funct3 == FUNCT3_C_ADDI && rd != 5'd0) begin
                        // addi rd, rd, imm
                        instr_o         = {imm_ci, rd, FUNCT3_ADD, rd, OPC_OP_IMM};
                        illegal_instr_o = 1'b0;
                    end else if (funct3 == FUNCT3_C_LI && rd != 5'd0) begin
                        // addi rd, x0, imm
                        instr_o         = {imm_ci, 5'd0, FUNCT3_ADD, rd, OPC_OP_IMM};
                        illegal_instr_o = 1'b0;
                    end
                end

                OPC_C2: begin
                    // rs2 of zero selects jr, jalr or ebreak, not supported
                    if (rd != 5'd0 && rs2 != 5'd0) begin
                        if (funct4 == FUNCT4_C_MV) begin
                            // add rd, x0, rs2
                            instr_o = {FUNCT7_ADD, rs2, 5'd0, FUNCT3_ADD, rd, OPC_OP};
                            illegal_instr_o = 1'b0;
                        end else if (funct4 == FUNCT4_C_ADD) begin
                            // add rd, rd, rs2
                            instr_o = {FUNCT7_ADD, rs2, rd, FUNCT3_ADD, rd, OPC_OP};
                            illegal_instr_o = 1'b0;
                        end
                    end
                end

                // loads, stores and addi4spn are all outside the subset
                OPC_C0: begin
                    illegal_instr_o = 1'b1;
                end

                default: begin
                    illegal_instr_o = 1'b1;
                end
            endcase
        end
    end

endmodule

// ==== source/fetch_if.sv ====
// --------------------------------------
// fetch interface
// carries fetched words from the prefetch
// buffer to the fetch stage
// --------------------------------------
`timescale 1ns/1ps

interface fetch_if import fetch_pkg::*; ();

    // entry in the FIFO head is valid, independent of ready
    logic         valid;
    logic         ready;
    fetch_entry_t entry;
    // drop everything held in the buffer
    logic         flush;

    modport producer (
        output valid,
        output entry,
        input  ready,
        input  flush
    );

    modport consumer (
        input  valid,
        input  entry,
        output ready,
        output flush
    );

endinterface

// ==== source/fetch_pkg.sv ====
// --------------------------------------
// fetch package
// address and instruction widths, the FIFO
// entry layout and the RVC encodings used by
// the compressed instruction expander
// --------------------------------------
package fetch_pkg;

    parameter int unsigned ADDR_W  = 32;
    parameter int unsigned INSTR_W = 32;

    // one fetched word together with its word address
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [INSTR_W-1:0] data;
    } fetch_entry_t;

    // RVC quadrants, bits [1:0] of a compressed word
    parameter logic [1:0] OPC_C0 = 2'b00;
    parameter logic [1:0] OPC_C1 = 2'b01;
    parameter logic [1:0] OPC_C2 = 2'b10;

    // 32-bit major opcodes produced by the expander
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_OP     = 7'b0110011;

    // compressed funct fields, funct3 is [15:13] and funct4 is [15:12]
    parameter logic [2:0] FUNCT3_C_ADDI = 3'b000;
    parameter logic [2:0] FUNCT3_C_LI   = 3'b010;
    parameter logic [3:0] FUNCT4_C_MV   = 4'b1000;
    parameter logic [3:0] FUNCT4_C_ADD  = 4'b1001;

    // funct fields of the expanded ADD and ADDI
    parameter logic [2:0] FUNCT3_ADD  = 3'b000;
    parameter logic [6:0] FUNCT7_ADD  = 7'b0000000;

endpackage

// ==== source/fetch_top.sv ====
// --------------------------------------
// instruction fetch top level
// fetch stage with its Wishbone read port
// --------------------------------------
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              flush_i,
    input  logic [ADDR_W-1:0] flush_addr_i,
    input  logic [ADDR_W-1:0] boot_addr_i,
    input  logic              id_ready_i,
    input  logic              halt_if_i,
    // Wishbone classic master, read only
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    // towards decode
    output logic              if_busy_o,
    output logic              instr_valid_id_o,
    output logic [31:0]       instr_rdata_id_o,
    output logic              is_compressed_id_o,
    output logic              illegal_c_insn_id_o,
    output logic [ADDR_W-1:0] pc_id_o
);

    if_stage #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_if_stage (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .req_i               (req_i),
        .flush_i             (flush_i),
        .flush_addr_i        (flush_addr_i),
        .boot_addr_i         (boot_addr_i),
        .id_ready_i          (id_ready_i),
        .halt_if_i           (halt_if_i),
        .wb_dat_i            (wb_dat_i),
        .wb_ack_i            (wb_ack_i),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_adr_o            (wb_adr_o),
        .if_busy_o           (if_busy_o),
        .instr_valid_id_o    (instr_valid_id_o),
        .instr_rdata_id_o    (instr_rdata_id_o),
        .is_compressed_id_o  (is_compressed_id_o),
        .illegal_c_insn_id_o (illegal_c_insn_id_o),
        .pc_id_o             (pc_id_o)
    );

endmodule

// ==== source/if_stage.sv ====
// --------------------------------------
// instruction fetch stage
// starts and restarts the prefetch buffer,
// expands compressed words and fills the
// IF/ID pipeline registers
// --------------------------------------
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              req_i,
    input  logic              flush_i,
    input  logic [ADDR_W-1:0] flush_addr_i,
    input  logic [ADDR_W-1:0] boot_addr_i,
    input  logic              id_ready_i,
    input  logic              halt_if_i,
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i,
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    output logic              if_busy_o,
    output logic              instr_valid_id_o,
    output logic [31:0]       instr_rdata_id_o,
    output logic              is_compressed_id_o,
    output logic              illegal_c_insn_id_o,
    output logic [ADDR_W-1:0] pc_id_o
);

    typedef enum logic {IDLE, WAIT} fsm_e;

    fsm_e               state_q;
    logic               branch;
    logic [ADDR_W-1:0]  branch_addr;
    logic               id_write;
    logic [INSTR_W-1:0] instr_exp;
    logic               instr_compressed;
    logic               illegal_c_insn;

    fetch_if fetch_bus ();

    prefetch_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_prefetch_buffer (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .branch_i      (branch),
        .branch_addr_i (branch_addr),
        .wb_cyc_o      (wb_cyc_o),
        .wb_stb_o      (wb_stb_o),
        .wb_adr_o      (wb_adr_o),
        .wb_dat_i      (wb_dat_i),
        .wb_ack_i      (wb_ack_i),
        .busy_o        (if_busy_o),
        .fetch         (fetch_bus.producer)
    );

    // expander sits on the FIFO head, before the IF/ID register
    compressed_decoder i_compressed_decoder (
        .instr_i         (fetch_bus.entry.data),
        .instr_o         (instr_exp),
        .is_compressed_o (instr_compressed),
        .illegal_instr_o (illegal_c_insn)
    );

    // --------------------------------------
    // fetch FSM
    // --------------------------------------
    // restart from boot on the first request, from flush_addr_i later on
    assign branch      = (state_q == IDLE) ? req_i : flush_i;
    assign branch_addr = (state_q == IDLE) ? boot_addr_i : flush_addr_i;

    assign fetch_bus.flush = flush_i & (state_q == WAIT);
    // no handover while stalled, halted or flushing
    assign fetch_bus.ready = (state_q == WAIT) & id_ready_i & ~halt_if_i & ~flush_i;
    assign id_write        = fetch_bus.valid & fetch_bus.ready;

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else if (state_q == IDLE && req_i) begin
            state_q <= WAIT;
        end
    end

    // --------------------------------------
    // IF/ID pipeline registers
    // --------------------------------------
    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            instr_valid_id_o    <= 1'b0;
            is_compressed_id_o  <= 1'b0;
            illegal_c_insn_id_o <= 1'b0;
        end else if (flush_i) begin
            instr_valid_id_o <= 1'b0;
        end else if (id_write) begin
            instr_valid_id_o    <= 1'b1;
            is_compressed_id_o  <= instr_compressed;
            illegal_c_insn_id_o <= illegal_c_insn;
        end else if (id_ready_i) begin
            // decode took the entry and nothing new arrived
            instr_valid_id_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (id_write) begin
            instr_rdata_id_o <= instr_exp;
            pc_id_o          <= fetch_bus.entry.addr;
        end
    end

endmodule

// ==== source/prefetch_buffer.sv ====
// --------------------------------------
// prefetch buffer
// read-only Wishbone classic master that
// fetches aligned words into a small FIFO,
// restarted by branch or flush
// --------------------------------------
`timescale 1ns/1ps

module prefetch_buffer import fetch_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              branch_i,
    input  logic [ADDR_W-1:0] branch_addr_i,
    // Wishbone classic, read only
    output logic              wb_cyc_o,
    output logic              wb_stb_o,
    output logic [ADDR_W-1:0] wb_adr_o,
    input  logic [31:0]       wb_dat_i,
    input  logic              wb_ack_i,
    output logic              busy_o,
    fetch_if.producer         fetch
);

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

    // --------------------------------------
    // request side
    // --------------------------------------
    logic              cyc_q;
    logic              discard_q;
    logic              active_q;
    logic [ADDR_W-1:0] next_addr_q;
    logic [ADDR_W-1:0] req_addr_q;
    logic              kill;
    logic              issue;
    logic [CNT_W:0]    fill;

    // FIFO state
    fetch_entry_t      mem_q [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              push;
    logic              pop;

    assign kill = branch_i | fetch.flush;

    // stored words plus the one in flight must leave room
    assign fill  = {1'b0, count_q} + {{CNT_W{1'b0}}, cyc_q};
    assign issue = active_q & ~cyc_q & ~kill & (fill < (CNT_W + 1)'(FIFO_DEPTH));

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            cyc_q       <= 1'b0;
            discard_q   <= 1'b0;
            active_q    <= 1'b0;
            next_addr_q <= '0;
            req_addr_q  <= '0;
        end else begin
            if (cyc_q) begin
                // cycle ends in the cycle after ack
                if (wb_ack_i) begin
                    cyc_q     <= 1'b0;
                    discard_q <= 1'b0;
                end else if (kill) begin
                    // let the transfer finish, its word is thrown away
                    discard_q <= 1'b1;
                end
            end else if (issue) begin
                cyc_q       <= 1'b1;
                req_addr_q  <= next_addr_q;
                next_addr_q <= next_addr_q + 32'd4;
            end
            // restart at a word aligned address
            if (branch_i) begin
                active_q    <= 1'b1;
                next_addr_q <= {branch_addr_i[ADDR_W-1:2], 2'b00};
            end
        end
    end

    assign wb_cyc_o = cyc_q;
    assign wb_stb_o = cyc_q;
    assign wb_adr_o = req_addr_q;

    // --------------------------------------
    // entry FIFO
    // --------------------------------------
    assign push = cyc_q & wb_ack_i & ~discard_q & ~kill;
    assign pop  = fetch.valid & fetch.ready;

    // storage only, the pointers say what is live
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= '{addr: req_addr_q, data: wb_dat_i};
        end
    end

    always_ff @(posedge clk_i, negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (kill) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign fetch.valid = (count_q != '0);
    assign fetch.entry = mem_q[rd_ptr_q];

    assign busy_o = cyc_q | (count_q != '0);

endmodule

// ==== tb/fetch_top_checker.sv ====
// --------------------------------------
// fetch top checker
// Wishbone protocol and IF/ID register
// properties, bound to the fetch top level
// --------------------------------------
`timescale 1ns/1ps

module fetch_top_checker import fetch_pkg::*; #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input logic                             clk_i,
    input logic                             rst_ni,
    input logic                             flush_i,
    input logic                             id_ready_i,
    input logic                             halt_if_i,
    input logic                             wb_cyc_o,
    input logic                             wb_stb_o,
    input logic [ADDR_W-1:0]                wb_adr_o,
    input logic                             wb_ack_i,
    input logic                             if_busy_o,
    input logic                             instr_valid_id_o,
    input logic [31:0]                      instr_rdata_id_o,
    input logic                             is_compressed_id_o,
    input logic                             illegal_c_insn_id_o,
    input logic [ADDR_W-1:0]                pc_id_o,
    input logic [$clog2(FIFO_DEPTH+1)-1:0]  fifo_count_i
);

    // number of failed properties
    int unsigned fail_count = 0;

    // --------------------------------------
    // Wishbone classic
    // --------------------------------------
    stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o |-> wb_cyc_o)
        else begin
            fail_count++;
            $error("wb_stb_o high without wb_cyc_o");
        end

    adr_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o))
        else begin
            fail_count++;
            $error("wb_adr_o changed before wb_ack_i");
        end

    ack_needs_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
        wb_ack_i |-> wb_stb_o)
        else begin
            fail_count++;
            $error("wb_ack_i seen without wb_stb_o");
        end

    // full FIFO must not start another read
    no_read_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fifo_count_i == FIFO_DEPTH |-> !wb_stb_o)
        else begin
            fail_count++;
            $error("wb_stb_o high with the FIFO full");
        end

    // --------------------------------------
    // IF/ID register
    // --------------------------------------
    id_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_valid_id_o && !id_ready_i && !flush_i |=> instr_valid_id_o
            && $stable(pc_id_o) && $stable(instr_rdata_id_o)
            && $stable(is_compressed_id_o) && $stable(illegal_c_insn_id_o))
        else begin
            fail_count++;
            $error("ID entry changed while decode stalled");
        end

    // halt keeps new entries out of the ID registers
    halt_holds_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
        halt_if_i |=> !$rose(instr_valid_id_o)
            && $stable(pc_id_o) && $stable(instr_rdata_id_o)
            && $stable(is_compressed_id_o) && $stable(illegal_c_insn_id_o))
        else begin
            fail_count++;
            $error("ID entry written while fetch halted");
        end

    // outputs quiet on the first edge out of reset
    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_ni) |-> !wb_cyc_o && !wb_stb_o && !instr_valid_id_o && !if_busy_o
            && !is_compressed_id_o && !illegal_c_insn_id_o)
        else begin
            fail_count++;
            $error("control outputs not low after reset");
        end

endmodule

// ==== tb/tb_fetch_top.sv ====
// --------------------------------------
// testbench for the fetch top level
// Wishbone memory model, IF/ID reference
// model, directed tests and watchdog
// --------------------------------------
`timescale 1ns/1ps

module tb_fetch_top import fetch_pkg::*; ();

    localparam int unsigned FIFO_DEPTH = 4;
    // ID entries consumed per test
    localparam int N_SEQ       = 16;
    localparam int N_EXP       = 16;
    localparam int N_ILL       = 16;
    localparam int N_BP        = 40;
    localparam int N_FLUSH     = 4;
    localparam int N_AFTER     = 8;
    localparam int TOTAL_WORDS = N_SEQ + N_EXP + N_ILL + N_BP + N_FLUSH * N_AFTER;

    // DUT inputs
    logic              clk        = 1'b0;
    logic              rst_n      = 1'b0;
    logic              req        = 1'b0;
    logic              flush      = 1'b0;
    logic [ADDR_W-1:0] flush_addr = '0;
    logic [ADDR_W-1:0] boot_addr  = '0;
    logic              id_ready   = 1'b1;
    logic              halt       = 1'b0;
    logic [31:0]       wb_dat     = '0;
    logic              wb_ack     = 1'b0;
    // DUT outputs
    logic              wb_cyc;
    logic              wb_stb;
    logic [ADDR_W-1:0] wb_adr;
    logic              if_busy;
    logic              instr_valid;
    logic [31:0]       instr_rdata;
    logic              is_compressed;
    logic              illegal_c;
    logic [ADDR_W-1:0] pc_id;

    integer            seed         = 82;
    string             test_name    = "reset";
    int                errors       = 0;
    int                err_mark     = 0;
    int                tests_passed = 0;
    int                tests_failed = 0;
    int                n_checked    = 0;
    int                n_rvc        = 0;
    int                n_illegal    = 0;
    int                wait_left    = -1;
    logic              slow_ack     = 1'b0;
    // 0 free running, 1 decode stalled, 2 random stalls
    logic [1:0]        stall_mode   = 2'd0;
    logic [ADDR_W-1:0] exp_pc       = '0;

    always #5 clk = ~clk;

    fetch_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_fetch_top (
        .clk_i               (clk),
        .rst_ni              (rst_n),
        .req_i               (req),
        .flush_i             (flush),
        .flush_addr_i        (flush_addr),
        .boot_addr_i         (boot_addr),
        .id_ready_i          (id_ready),
        .halt_if_i           (halt),
        .wb_dat_i            (wb_dat),
        .wb_ack_i            (wb_ack),
        .wb_cyc_o            (wb_cyc),
        .wb_stb_o            (wb_stb),
        .wb_adr_o            (wb_adr),
        .if_busy_o           (if_busy),
        .instr_valid_id_o    (instr_valid),
        .instr_rdata_id_o    (instr_rdata),
        .is_compressed_id_o  (is_compressed),
        .illegal_c_insn_id_o (illegal_c),
        .pc_id_o             (pc_id)
    );

    bind fetch_top fetch_top_checker #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_checker (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .flush_i             (flush_i),
        .id_ready_i          (id_ready_i),
        .halt_if_i           (halt_if_i),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_adr_o            (wb_adr_o),
        .wb_ack_i            (wb_ack_i),
        .if_busy_o           (if_busy_o),
        .instr_valid_id_o    (instr_valid_id_o),
        .instr_rdata_id_o    (instr_rdata_id_o),
        .is_compressed_id_o  (is_compressed_id_o),
        .illegal_c_insn_id_o (illegal_c_insn_id_o),
        .pc_id_o             (pc_id_o),
        .fifo_count_i        (i_if_stage.i_prefetch_buffer.count_q)
    );

    // --------------------------------------
    // memory table and expansion rule
    // --------------------------------------
    // eight word slots with contents folded from the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [15:0] h;
        logic [4:0]  rd;
        logic [4:0]  rs;
        h  = addr[31:16] ^ addr[15:0];
        rd = {h[11:8], 1'b1};
        rs = {h[14:11], 1'b1};
        case (addr[4:2])
            3'd3:    return {h, 3'b000, h[4], rd, h[9:5], 2'b01};
            3'd4:    return {h, 3'b010, h[4], rd, h[9:5], 2'b01};
            3'd5:    return {h, 4'b1000, rd, rs, 2'b10};
            3'd6:    return {h, 4'b1001, rd, rs, 2'b10};
            // c.jr x1 or a quadrant 0 code lies outside the subset
            3'd7:    return h[5] ? {h, 16'h8082} : {h, h[15:2], 2'b00};
            default: return {h[15:4], h[7:3], 3'b000, h[12:8], 7'b0010011};
        endcase
    endfunction

    // result is {illegal, compressed, word}
    function automatic logic [33:0] expand(input logic [31:0] w);
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd  = w[11:7];
        rs2 = w[6:2];
        imm = {{7{w[12]}}, w[6:2]};
        if (w[1:0] == 2'b11)
            return {2'b00, w};
        if (w[1:0] == 2'b01 && w[15:13] == 3'b000 && rd != 5'd0)
            return {2'b01, imm, rd, 3'b000, rd, 7'h13};
        if (w[1:0] == 2'b01 && w[15:13] == 3'b010 && rd != 5'd0)
            return {2'b01, imm, 5'd0, 3'b000, rd, 7'h13};
        if (w[1:0] == 2'b10 && w[15:12] == 4'b1000 && rd != 5'd0 && rs2 != 5'd0)
            return {2'b01, 7'd0, rs2, 5'd0, 3'b000, rd, 7'h33};
        if (w[1:0] == 2'b10 && w[15:12] == 4'b1001 && rd != 5'd0 && rs2 != 5'd0)
            return {2'b01, 7'd0, rs2, rd, 3'b000, rd, 7'h33};
        return {2'b11, 32'd0};
    endfunction

    function automatic int error_total();
        return errors + int'(i_fetch_top.i_checker.fail_count);
    endfunction

    // --------------------------------------
    // Wishbone slave and decode stall driver
    // --------------------------------------
    // one transfer at a time with ack after 0 to 3 wait cycles
    always @(posedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (rst_n && wb_cyc && wb_stb) begin
            if (wait_left < 0) begin
                wait_left = slow_ack ? 3 : int'({$random(seed)} % 4);
            end
            if (wait_left == 0) begin
                wb_ack    <= 1'b1;
                wb_dat    <= mem_word(wb_adr);
                wait_left = -1;
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clk) begin : stall_drive
        logic [31:0] r;
        case (stall_mode)
            2'd1: begin
                id_ready <= 1'b0;
                halt     <= 1'b0;
            end
            2'd2: begin
                r = $random(seed);
                id_ready <= r[0] | r[1];
                halt     <= r[2] & r[3];
            end
            default: begin
                id_ready <= 1'b1;
                halt     <= 1'b0;
            end
        endcase
    end

    // --------------------------------------
    // reference check of consumed ID entries
    // --------------------------------------
    // sampled mid-cycle since the entry leaves ID on the next rising edge
    always @(negedge clk) begin : ref_check
        logic [33:0] exp_id;
        if (rst_n && instr_valid && id_ready) begin
            exp_id = expand(mem_word(exp_pc));
            assert (pc_id == exp_pc) else begin
                $display("** Error [%s] pc: expected %h, actual %h", test_name, exp_pc, pc_id);
                errors++;
            end
            assert (instr_rdata == exp_id[31:0]) else begin
                $display("** Error [%s] instr at %h: expected %h, actual %h",
                         test_name, exp_pc, exp_id[31:0], instr_rdata);
                errors++;
            end
            assert (is_compressed == exp_id[32] && illegal_c == exp_id[33]) else begin
                $display("** Error [%s] flags at %h: expected %b, actual %b",
                         test_name, exp_pc, exp_id[33:32], {illegal_c, is_compressed});
                errors++;
            end
            n_checked++;
            if (exp_id[33]) begin
                n_illegal++;
            end else if (exp_id[32]) begin
                n_rvc++;
            end
            exp_pc = exp_pc + 32'd4;
        end
        // restart points of the expected stream
        if (req) begin
            exp_pc = boot_addr;
        end
        if (flush) begin
            exp_pc = flush_addr;
        end
    end

    // --------------------------------------
    // test sequence
    // --------------------------------------
    task automatic start_test(input string name);
        test_name = name;
        err_mark  = error_total();
    endtask

    task automatic finish_test();
        int n;
        n = error_total() - err_mark;
        if (n == 0) begin
            tests_passed++;
            $display("test %s: ok, %0d entries checked so far", test_name, n_checked);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, n);
        end
    endtask

    // blocks until n more entries have left ID
    task automatic wait_words(input int n);
        int target;
        target = n_checked + n;
        while (n_checked < target) begin
            @(posedge clk);
        end
    endtask

    task automatic restart(input logic [31:0] addr);
        flush_addr <= addr;
        flush      <= 1'b1;
        @(posedge clk);
        flush      <= 1'b0;
    endtask

    initial begin : test_seq
        int mark;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        start_test("sequential");
        req       <= 1'b1;
        boot_addr <= 32'h0000_1000;
        @(posedge clk);
        req <= 1'b0;
        wait_words(N_SEQ);
        finish_test();

        start_test("expansion");
        mark = n_rvc;
        restart(32'h0002_0040);
        wait_words(N_EXP);
        assert (n_rvc > mark) else begin
            $display("expansion test reached no compressed entry");
            errors++;
        end
        finish_test();

        start_test("illegal");
        mark = n_illegal;
        restart(32'h0013_0f00);
        wait_words(N_ILL);
        assert (n_illegal > mark) else begin
            $display("illegal test reached no illegal compressed entry");
            errors++;
        end
        finish_test();

        // long stall first so the FIFO fills up
        start_test("backpressure");
        stall_mode <= 2'd1;
        repeat (40) @(posedge clk);
        stall_mode <= 2'd2;
        wait_words(N_BP);
        stall_mode <= 2'd0;
        finish_test();

        // flush while a slow transfer is still open
        start_test("flush");
        for (int i = 0; i < N_FLUSH; i++) begin
            slow_ack <= 1'b1;
            do begin
                @(posedge clk);
            end while (!(wb_cyc && !wb_ack));
            restart(32'h0000_8000 + i * 32'h124);
            slow_ack <= 1'b0;
            wait_words(N_AFTER);
        end
        finish_test();

        $display("done: %0d tests passed, %0d failed, %0d entries checked, %0d errors",
                 tests_passed, tests_failed, n_checked, error_total());
        if (tests_failed == 0 && error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // ten cycles per consumed word
    initial begin : watchdog
        #(TOTAL_WORDS * 10 * 10);
        $display("timeout: test %s did not finish in time", test_name);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
